//--- design/lb_pkg.sv
// Local bus definitions
package lb_pkg;

	localparam int lb_aw = 24;
	localparam int lb_dw = 32;
	localparam int mirror_aw = 5;

	typedef logic [lb_aw-1:0] lb_addr_t;
	typedef logic [lb_dw-1:0] lb_data_t;

	// Returned for any address outside a mapped region
	localparam lb_data_t miss_word = 32'hdeadbeef;

	// Page numbers in address bits 23:16
	localparam logic [7:0] status_page = 8'h00;
	localparam logic [7:0] ctrl_page = 8'h05;

	typedef enum logic [1:0] {
		region_status = 2'd0,
		region_ctrl = 2'd1,
		region_none = 2'd2
	} lb_region_e;

	// Status register select, address bits 3:0
	typedef enum logic [3:0] {
		st_hello_0 = 4'h0,
		st_hello_1 = 4'h1,
		st_hello_2 = 4'h2,
		st_hello_3 = 4'h3,
		st_fault_count = 4'h4,
		st_uptime = 4'h5,
		st_misc_cfg = 4'h6
	} status_sel_e;

	// Direct-write select, address bits 4:0
	typedef enum logic [4:0] {
		wr_led_mode = 5'd1,
		wr_led1_duty = 5'd2,
		wr_led2_duty = 5'd3,
		wr_misc_cfg = 5'd8
	} ctrl_sel_e;

	// Status page also needs bits 7:4 clear, control page covers control and mirror
	function automatic lb_region_e region_of(input lb_addr_t a);
		if (a[23:16] == status_page && a[7:4] == 4'h0)
			return region_status;
		else if (a[23:16] == ctrl_page)
			return region_ctrl;
		else
			return region_none;
	endfunction

endpackage

//--- design/board_pkg.sv
// Board control definitions
package board_pkg;

	typedef logic [7:0] duty_t;
	typedef logic [7:0] misc_cfg_t;
	typedef logic [1:0] led_mode_t;

	// Bit positions inside the misc configuration byte
	localparam int misc_cfg_d02_bit = 0;
	localparam int misc_mmc_int_bit = 1;
	localparam int misc_allow_eth_bit = 2;
	localparam int misc_zest_pwr_bit = 3;
	localparam int misc_ext_lsb = 4;
	localparam int ext_config_w = 4;

	localparam misc_cfg_t misc_cfg_reset = 8'h00;

endpackage

//--- design/lb_req_if.sv
// Local bus request
`timescale 1ns/10ps

interface lb_req_if;

	lb_pkg::lb_addr_t addr;
	logic strobe;
	// High for a read, low for a write
	logic rd;
	lb_pkg::lb_data_t wdata;

	modport host (
		output addr,
		output strobe,
		output rd,
		output wdata
	);

	modport slave (
		input addr,
		input strobe,
		input rd,
		input wdata
	);

endinterface

//--- design/status_bank.sv
// Status register bank
`timescale 1ns/10ps

module status_bank (
	input logic clk,
	input logic reset,
	lb_req_if.slave bus,
	input logic xdomain_fault,
	input logic led_tick,
	input board_pkg::misc_cfg_t misc_cfg,
	output lb_pkg::lb_data_t status_word
);

	localparam lb_pkg::lb_data_t hello_0 = "Hell";
	localparam lb_pkg::lb_data_t hello_1 = "o wo";
	localparam lb_pkg::lb_data_t hello_2 = "rld!";
	localparam lb_pkg::lb_data_t hello_3 = "(::)";

	logic do_rd;
	logic [15:0] fault_count;
	logic [31:0] uptime;
	lb_pkg::status_sel_e sel;

	assign do_rd = bus.strobe & bus.rd;
	assign sel = lb_pkg::status_sel_e'(bus.addr[3:0]);

	// ------------------------------------------------------------------
	// Counters
	// ------------------------------------------------------------------

	// Bursts are expected while the PHY clock tree comes up
	always_ff @(posedge clk) begin
		if (reset) begin
			fault_count <= '0;
		end else if (xdomain_fault) begin
			fault_count <= fault_count + 16'd1;
		end
	end

	// One count per LED period
	always_ff @(posedge clk) begin
		if (reset) begin
			uptime <= '0;
		end else if (led_tick) begin
			uptime <= uptime + 32'd1;
		end
	end

	// ------------------------------------------------------------------
	// First read stage
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (do_rd) begin
			case (sel)
				lb_pkg::st_hello_0: status_word <= hello_0;
				lb_pkg::st_hello_1: status_word <= hello_1;
				lb_pkg::st_hello_2: status_word <= hello_2;
				lb_pkg::st_hello_3: status_word <= hello_3;
				lb_pkg::st_fault_count: status_word <= {16'h0000, fault_count};
				lb_pkg::st_uptime: status_word <= uptime;
				lb_pkg::st_misc_cfg: status_word <= {24'h000000, misc_cfg};
				default: status_word <= '0;
			endcase
		end
	end

	// Uptime only moves after a wrap of the LED counter
	uptime_follows_tick: assert property (@(posedge clk) disable iff (reset)
		$changed(uptime) |-> ($past(led_tick) || $past(reset)));

endmodule

//--- design/ctrl_regs.sv
// Direct-write control registers
`timescale 1ns/10ps

module ctrl_regs #(
	parameter board_pkg::misc_cfg_t misc_config_default = board_pkg::misc_cfg_reset
) (
	input logic clk,
	input logic reset,
	lb_req_if.slave bus,
	output board_pkg::led_mode_t led_user_mode,
	output board_pkg::duty_t led1_duty,
	output board_pkg::duty_t led2_duty,
	output board_pkg::misc_cfg_t misc_cfg,
	output lb_pkg::lb_data_t mirror_word
);

	localparam int mirror_depth = 2 ** lb_pkg::mirror_aw;

	logic local_write;
	logic [lb_pkg::mirror_aw-1:0] mirror_addr;
	lb_pkg::ctrl_sel_e sel;
	lb_pkg::lb_data_t mirror_mem [0:mirror_depth-1];

	// Writes to the control page land in both the registers and the mirror
	assign local_write = bus.strobe & ~bus.rd
		& (lb_pkg::region_of(bus.addr) == lb_pkg::region_ctrl);
	assign mirror_addr = bus.addr[lb_pkg::mirror_aw-1:0];
	assign sel = lb_pkg::ctrl_sel_e'(bus.addr[4:0]);

	// ------------------------------------------------------------------
	// Control registers
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			led_user_mode <= '0;
			led1_duty <= '0;
			led2_duty <= '0;
			misc_cfg <= misc_config_default;
		end else if (local_write) begin
			case (sel)
				lb_pkg::wr_led_mode: led_user_mode <= bus.wdata[1:0];
				lb_pkg::wr_led1_duty: led1_duty <= bus.wdata[7:0];
				lb_pkg::wr_led2_duty: led2_duty <= bus.wdata[7:0];
				lb_pkg::wr_misc_cfg: misc_cfg <= bus.wdata[7:0];
				default: ;
			endcase
		end
	end

	// ------------------------------------------------------------------
	// Mirror memory
	// ------------------------------------------------------------------

	// Every control write is kept so the host can read it back
	always_ff @(posedge clk) begin
		if (local_write) begin
			mirror_mem[mirror_addr] <= bus.wdata;
		end
	end

	// Registered read, one cycle behind the address
	always_ff @(posedge clk) begin
		mirror_word <= mirror_mem[mirror_addr];
	end

	// Host must hold a known strobe once out of reset
	strobe_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(bus.strobe));

endmodule

//--- design/led_pwm.sv
// LED PWM and wrap tick
`timescale 1ns/10ps

module led_pwm #(
	parameter int led_cw = 10
) (
	input logic clk,
	input logic reset,
	input board_pkg::duty_t led1_duty,
	input board_pkg::duty_t led2_duty,
	output logic led1,
	output logic led2,
	output logic led_tick
);

	logic [led_cw-1:0] led_cc;
	logic [led_cw-1:0] thresh_1;
	logic [led_cw-1:0] thresh_2;

	// Duty factor scaled by four against the counter
	assign thresh_1 = led_cw'({led1_duty, 2'b00});
	assign thresh_2 = led_cw'({led2_duty, 2'b00});

	// Carry out of the counter is the wrap tick
	always_ff @(posedge clk) begin
		if (reset) begin
			led_cc <= '0;
			led_tick <= 1'b0;
		end else begin
			{led_tick, led_cc} <= {1'b0, led_cc} + 1'b1;
		end
	end

	// Compare output is one cycle behind the counter
	always_ff @(posedge clk) begin
		if (reset) begin
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			led1 <= led_cc < thresh_1;
			led2 <= led_cc < thresh_2;
		end
	end

	tick_single: assert property (@(posedge clk) disable iff (reset)
		led_tick |=> !led_tick);

endmodule

//--- design/read_mux.sv
// Second read stage
`timescale 1ns/10ps

module read_mux (
	input logic clk,
	input logic reset,
	lb_req_if.slave bus,
	input lb_pkg::lb_data_t status_word,
	input lb_pkg::lb_data_t mirror_word,
	output lb_pkg::lb_data_t data_in
);

	logic do_rd_r;
	lb_pkg::lb_addr_t addr_r;
	lb_pkg::lb_region_e region_r;

	// ------------------------------------------------------------------
	// Stage one
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			do_rd_r <= 1'b0;
		end else begin
			do_rd_r <= bus.strobe & bus.rd;
		end
	end

	always_ff @(posedge clk) begin
		addr_r <= bus.addr;
	end

	assign region_r = lb_pkg::region_of(addr_r);

	// ------------------------------------------------------------------
	// Stage two
	// ------------------------------------------------------------------

	// Holds the last read result until the next read
	always_ff @(posedge clk) begin
		if (reset) begin
			data_in <= '0;
		end else if (do_rd_r) begin
			case (region_r)
				lb_pkg::region_status: data_in <= status_word;
				lb_pkg::region_ctrl: data_in <= mirror_word;
				default: data_in <= lb_pkg::miss_word;
			endcase
		end
	end

	// Catches reads of unwritten mirror words or a bad first stage
	data_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(data_in));

endmodule

//--- design/marble_lb_slave.sv
// Marble local bus slave
`timescale 1ns/10ps

module marble_lb_slave #(
	parameter int led_cw = 10,
	parameter board_pkg::misc_cfg_t misc_config_default = board_pkg::misc_cfg_reset
) (
	input logic clk,
	input logic reset,
	input lb_pkg::lb_addr_t addr,
	input logic control_strobe,
	input logic control_rd,
	input lb_pkg::lb_data_t data_out,
	input logic xdomain_fault,
	output lb_pkg::lb_data_t data_in,
	output board_pkg::led_mode_t led_user_mode,
	output logic led1,
	output logic led2,
	output logic cfg_d02,
	output logic mmc_int,
	output logic allow_mmc_eth_config,
	output logic zest_pwr_en,
	output logic [board_pkg::ext_config_w-1:0] ext_config
);

	logic led_tick;
	board_pkg::duty_t led1_duty;
	board_pkg::duty_t led2_duty;
	board_pkg::misc_cfg_t misc_cfg;
	lb_pkg::lb_data_t status_word;
	lb_pkg::lb_data_t mirror_word;

	lb_req_if lb_bus ();

	assign lb_bus.addr = addr;
	assign lb_bus.strobe = control_strobe;
	assign lb_bus.rd = control_rd;
	assign lb_bus.wdata = data_out;

	// ------------------------------------------------------------------
	// Blocks
	// ------------------------------------------------------------------
	status_bank status_i (
		.clk(clk),
		.reset(reset),
		.bus(lb_bus.slave),
		.xdomain_fault(xdomain_fault),
		.led_tick(led_tick),
		.misc_cfg(misc_cfg),
		.status_word(status_word)
	);

	ctrl_regs #(
		.misc_config_default(misc_config_default)
	) ctrl_i (
		.clk(clk),
		.reset(reset),
		.bus(lb_bus.slave),
		.led_user_mode(led_user_mode),
		.led1_duty(led1_duty),
		.led2_duty(led2_duty),
		.misc_cfg(misc_cfg),
		.mirror_word(mirror_word)
	);

	led_pwm #(
		.led_cw(led_cw)
	) pwm_i (
		.clk(clk),
		.reset(reset),
		.led1_duty(led1_duty),
		.led2_duty(led2_duty),
		.led1(led1),
		.led2(led2),
		.led_tick(led_tick)
	);

	read_mux rmux_i (
		.clk(clk),
		.reset(reset),
		.bus(lb_bus.slave),
		.status_word(status_word),
		.mirror_word(mirror_word),
		.data_in(data_in)
	);

	// Misc config bits out to the board
	assign cfg_d02 = misc_cfg[board_pkg::misc_cfg_d02_bit];
	assign mmc_int = misc_cfg[board_pkg::misc_mmc_int_bit];
	assign allow_mmc_eth_config = misc_cfg[board_pkg::misc_allow_eth_bit];
	assign zest_pwr_en = misc_cfg[board_pkg::misc_zest_pwr_bit];
	assign ext_config = misc_cfg[board_pkg::misc_ext_lsb +: board_pkg::ext_config_w];

endmodule

//--- test/tb_marble_lb_slave.sv
// Local bus slave testbench
`timescale 1ns/10ps

module tb_marble_lb_slave;

	// One LED period with the default counter width of 10 bits
	localparam int led_period = 1024;
	localparam int timeout_cycles = 6000;
	localparam logic [7:0] misc_default = 8'h00;

	logic clk;
	logic reset;
	lb_pkg::lb_addr_t addr;
	logic control_strobe;
	logic control_rd;
	lb_pkg::lb_data_t data_out;
	logic xdomain_fault;
	lb_pkg::lb_data_t data_in;
	board_pkg::led_mode_t led_user_mode;
	logic led1;
	logic led2;
	logic cfg_d02;
	logic mmc_int;
	logic allow_mmc_eth_config;
	logic zest_pwr_en;
	logic [3:0] ext_config;

	// Reference model state
	lb_pkg::lb_data_t mirror_model [0:31];
	logic [1:0] mode_model;
	logic [7:0] duty1_model;
	logic [7:0] duty2_model;
	logic [7:0] misc_model;
	logic [15:0] fault_model;
	lb_pkg::lb_data_t uptime_model;

	// Expected read words in issue order and their compare flags
	lb_pkg::lb_data_t exp_q [$];
	bit chk_q [$];
	int cycle_count = 0;

	marble_lb_slave dut_i (
		.clk(clk),
		.reset(reset),
		.addr(addr),
		.control_strobe(control_strobe),
		.control_rd(control_rd),
		.data_out(data_out),
		.xdomain_fault(xdomain_fault),
		.data_in(data_in),
		.led_user_mode(led_user_mode),
		.led1(led1),
		.led2(led2),
		.cfg_d02(cfg_d02),
		.mmc_int(mmc_int),
		.allow_mmc_eth_config(allow_mmc_eth_config),
		.zest_pwr_en(zest_pwr_en),
		.ext_config(ext_config)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= timeout_cycles)
			abort_run("Timeout: the tests did not finish within the cycle limit");
	end

	// ----------------------------------------------------------------------
	// Reference model and checks
	// ----------------------------------------------------------------------
	function automatic lb_pkg::lb_data_t expected_read(input lb_pkg::lb_addr_t a);
		if (a[23:16] == 8'h00 && a[7:4] == 4'h0) begin
			case (a[3:0])
				4'h0: return 32'h48656c6c;
				4'h1: return 32'h6f20776f;
				4'h2: return 32'h726c6421;
				4'h3: return 32'h283a3a29;
				4'h4: return {16'h0000, fault_model};
				4'h5: return uptime_model;
				4'h6: return {24'h000000, misc_model};
				default: return 32'h00000000;
			endcase
		end else if (a[23:16] == 8'h05) begin
			return mirror_model[a[4:0]];
		end
		return 32'hdeadbeef;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, want);
			$display(">>> FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic check_outputs();
		check_value("led_user_mode", 32'(led_user_mode), 32'(mode_model));
		check_value("cfg_d02", 32'(cfg_d02), 32'(misc_model[0]));
		check_value("mmc_int", 32'(mmc_int), 32'(misc_model[1]));
		check_value("allow_mmc_eth_config", 32'(allow_mmc_eth_config), 32'(misc_model[2]));
		check_value("zest_pwr_en", 32'(zest_pwr_en), 32'(misc_model[3]));
		check_value("ext_config", 32'(ext_config), 32'(misc_model[7:4]));
	endtask

	// Data of a read seen at one edge is due right after the next edge
	initial begin : compare_reads
		bit issued;
		bit pending;
		bit chk;
		lb_pkg::lb_data_t want;
		pending = 1'b0;
		forever begin
			@(posedge clk);
			issued = control_strobe && control_rd && !reset;
			#2;
			if (pending) begin
				if (exp_q.size() == 0)
					abort_run("Read data arrived with no expected word queued");
				want = exp_q.pop_front();
				chk = chk_q.pop_front();
				if (chk)
					check_value("data_in", data_in, want);
			end
			pending = issued;
		end
	end

	// ----------------------------------------------------------------------
	// Bus tasks entered and left 1 ns after a rising edge
	// ----------------------------------------------------------------------
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic bus_idle();
		control_strobe = 1'b0;
		control_rd = 1'b0;
	endtask

	task automatic issue_read(input lb_pkg::lb_addr_t a, input bit chk);
		addr = a;
		control_strobe = 1'b1;
		control_rd = 1'b1;
		exp_q.push_back(expected_read(a));
		chk_q.push_back(chk);
		wait_cycles(1);
	endtask

	task automatic bus_read(input lb_pkg::lb_addr_t a, input bit chk,
		output lb_pkg::lb_data_t d);
		issue_read(a, chk);
		bus_idle();
		wait_cycles(1);
		d = data_in;
	endtask

	task automatic bus_write(input lb_pkg::lb_addr_t a, input lb_pkg::lb_data_t d);
		addr = a;
		data_out = d;
		control_strobe = 1'b1;
		control_rd = 1'b0;
		if (a[23:16] == 8'h05) begin
			mirror_model[a[4:0]] = d;
			case (a[4:0])
				5'd1: mode_model = d[1:0];
				5'd2: duty1_model = d[7:0];
				5'd3: duty2_model = d[7:0];
				5'd8: misc_model = d[7:0];
				default: ;
			endcase
		end
		wait_cycles(1);
		bus_idle();
	endtask

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------
	initial begin : run_tests
		int unsigned seed_val;
		int i;
		int fault_len;
		int high_1;
		int high_2;
		lb_pkg::lb_data_t word;
		lb_pkg::lb_data_t up_first;
		lb_pkg::lb_addr_t wr_addr [0:7];

		seed_val = $urandom(32'h78df_b892);
		reset = 1'b1;
		addr = '0;
		control_strobe = 1'b0;
		control_rd = 1'b0;
		data_out = '0;
		xdomain_fault = 1'b0;
		mode_model = '0;
		duty1_model = '0;
		duty2_model = '0;
		misc_model = misc_default;
		fault_model = '0;
		uptime_model = '0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		// Reset state
		check_value("data_in", data_in, 32'h00000000);
		check_outputs();

		// Greeting words back to back, then unmapped and unused addresses
		for (i = 0; i < 4; i++)
			issue_read(lb_pkg::lb_addr_t'(i), 1'b1);
		issue_read(24'h020000, 1'b1);
		issue_read(24'h000013, 1'b1);
		issue_read(24'h00000b, 1'b1);
		bus_idle();
		wait_cycles(3);

		// Random control page writes read back from the mirror
		for (i = 0; i < 8; i++) begin
			wr_addr[i] = {8'h05, 11'($urandom), 5'($urandom)};
			bus_write(wr_addr[i], $urandom);
		end
		for (i = 0; i < 8; i++)
			issue_read(wr_addr[i], 1'b1);
		bus_idle();
		wait_cycles(3);

		bus_write(24'h050001, $urandom);
		bus_write(24'h050008, $urandom);
		check_outputs();
		bus_read(24'h000006, 1'b1, word);
		bus_read(24'h050008, 1'b1, word);

		// Fault burst of known length
		fault_len = 5 + int'($urandom % 40);
		xdomain_fault = 1'b1;
		wait_cycles(fault_len);
		xdomain_fault = 1'b0;
		fault_model = fault_model + 16'(fault_len);
		bus_read(24'h000004, 1'b1, word);

		// PWM high time over one full LED period
		bus_write(24'h050002, 32'($urandom % 256));
		bus_write(24'h050003, 32'($urandom % 256));
		wait_cycles(2);
		high_1 = 0;
		high_2 = 0;
		repeat (led_period) begin
			if (led1)
				high_1++;
			if (led2)
				high_2++;
			wait_cycles(1);
		end
		check_value("led1", 32'(high_1), 32'(duty1_model) * 32'd4);
		check_value("led2", 32'(high_2), 32'(duty2_model) * 32'd4);

		// Two uptime reads whose strobes are exactly one period apart
		bus_read(24'h000005, 1'b0, up_first);
		uptime_model = up_first + 32'd1;
		wait_cycles(led_period - 2);
		bus_read(24'h000005, 1'b1, word);

		wait_cycles(3);
		if (exp_q.size() == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- files.f
design/lb_pkg.sv
design/board_pkg.sv
design/lb_req_if.sv
design/status_bank.sv
design/ctrl_regs.sv
design/led_pwm.sv
design/read_mux.sv
design/marble_lb_slave.sv
test/tb_marble_lb_slave.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_marble_lb_slave -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -q -x -F '>>> PASS' \
	&& echo "Simulation result: passed" \
	|| { echo "Simulation result: failed"; exit 1; }
